/* all.f */
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/branch_unit.sv
logic/ex_issue_reg.sv
logic/branch_predictor.sv
logic/ex_result_reg.sv
logic/branch_ex_top.sv
test/branch_ex_properties.sv
test/branch_ex_tb.sv

/* logic/branch_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_ex_top
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int unsigned BP_INDEX_BITS = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  ex_issue_t    issue_in,
    output br_wb_t       wb,
    output br_redirect_t redirect,
    input  word_t        fetch_pc,
    output logic         pred_hit,
    output logic         pred_taken,
    output word_t        pred_target
);

    ex_issue_t    issue;
    br_wb_t       wb_d;
    br_redirect_t redirect_d;
    bp_update_t   update;
    logic         squash;

    ex_issue_reg u_issue_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue_in (issue_in),
        .squash   (squash),
        .issue    (issue)
    );

    branch_unit u_branch_unit (
        .issue    (issue),
        .wb       (wb_d),
        .redirect (redirect_d),
        .update   (update),
        .squash   (squash)
    );

    ex_result_reg u_result_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_in       (wb_d),
        .redirect_in (redirect_d),
        .wb          (wb),
        .redirect    (redirect)
    );

    branch_predictor #(
        .BP_INDEX_BITS (BP_INDEX_BITS)
    ) u_predictor (
        .clk         (clk),
        .rst_n       (rst_n),
        .update      (update),
        .fetch_pc    (fetch_pc),
        .pred_hit    (pred_hit),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

endmodule

`default_nettype wire

/* logic/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int unsigned BP_INDEX_BITS = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  bp_update_t update,
    input  word_t      fetch_pc,
    output logic       pred_hit,
    output logic       pred_taken,
    output word_t      pred_target
);

    localparam int unsigned OFFSET_BITS = $clog2(INSN_BYTES);
    localparam int unsigned TAG_BITS    = $bits(word_t) - BP_INDEX_BITS - OFFSET_BITS;
    localparam int unsigned ENTRIES     = 1 << BP_INDEX_BITS;

    typedef logic [BP_INDEX_BITS-1:0] bp_index_t;
    typedef logic [TAG_BITS-1:0]      bp_tag_t;
    typedef logic [1:0]               bp_ctr_t;

    logic [ENTRIES-1:0] valid_q;
    bp_tag_t            tag_q    [ENTRIES];
    word_t              target_q [ENTRIES];
    br_category_t       cat_q    [ENTRIES];
    bp_ctr_t            ctr_q    [ENTRIES];

    bp_index_t upd_idx;
    bp_tag_t   upd_tag;
    logic      upd_match;
    bp_ctr_t   upd_ctr;
    bp_index_t rd_idx;
    bp_tag_t   rd_tag;

    // ------------------------------------------------------------------------
    // Training
    // ------------------------------------------------------------------------

    assign upd_idx   = update.pc[OFFSET_BITS +: BP_INDEX_BITS];
    assign upd_tag   = update.pc[OFFSET_BITS + BP_INDEX_BITS +: TAG_BITS];
    assign upd_match = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // Saturating counter on a match, weak state on a new entry
    always_comb begin
        if (!upd_match) begin
            upd_ctr = update.taken ? 2'd2 : 2'd1;
        end else if (update.taken) begin
            upd_ctr = (ctr_q[upd_idx] == 2'd3) ? 2'd3 : ctr_q[upd_idx] + 2'd1;
        end else begin
            upd_ctr = (ctr_q[upd_idx] == 2'd0) ? 2'd0 : ctr_q[upd_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (update.valid) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= update.target;
            cat_q[upd_idx]    <= update.category;
            ctr_q[upd_idx]    <= upd_ctr;
        end
    end

    // ------------------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------------------

    assign rd_idx = fetch_pc[OFFSET_BITS +: BP_INDEX_BITS];
    assign rd_tag = fetch_pc[OFFSET_BITS + BP_INDEX_BITS +: TAG_BITS];

    assign pred_hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    // Unconditional branches are always predicted taken
    assign pred_taken  = pred_hit && (cat_q[rd_idx] != COND || ctr_q[rd_idx][1]);
    assign pred_target = target_q[rd_idx];

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  ex_issue_t    issue,
    output br_wb_t       wb,
    output br_redirect_t redirect,
    output bp_update_t   update,
    output logic         squash
);

    localparam int unsigned OFFSET_BITS = $clog2(INSN_BYTES);

    word_t        seq_pc;
    word_t        offset;
    word_t        taken_target;
    word_t        next_pc;
    logic         taken;
    br_category_t category;

    assign seq_pc = issue.pc + word_t'(INSN_BYTES);
    assign offset = issue.imm << OFFSET_BITS;

    // ------------------------------------------------------------------------
    // Direction and target
    // ------------------------------------------------------------------------

    always_comb begin
        case (issue.op)
            JIRL, B, BL: taken = 1'b1;
            BEQ:         taken = (issue.sr0 == issue.sr1);
            BNE:         taken = (issue.sr0 != issue.sr1);
            BLT:         taken = ($signed(issue.sr0) <  $signed(issue.sr1));
            BGE:         taken = ($signed(issue.sr0) >= $signed(issue.sr1));
            BLTU:        taken = (issue.sr0 <  issue.sr1);
            BGEU:        taken = (issue.sr0 >= issue.sr1);
            default:     taken = 1'b0;
        endcase
    end

    // Only JIRL is register relative
    assign taken_target = (issue.op == JIRL) ? issue.sr0 + offset : issue.pc + offset;
    assign next_pc      = taken ? taken_target : seq_pc;

    always_comb begin
        case (issue.op)
            JIRL:    category = INDIRECT;
            B, BL:   category = DIRECT;
            default: category = COND;
        endcase
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    always_comb begin
        wb.en   = issue.en;
        wb.data = issue.en ? seq_pc : '0;
        if (issue.en && issue.op == JIRL) begin
            wb.rd = issue.rd;
        end else if (issue.en && issue.op == BL) begin
            wb.rd = LINK_REG;
        end else begin
            wb.rd = '0;
        end
    end

    always_comb begin
        redirect.flush  = issue.en && (next_pc != issue.pc_next);
        redirect.target = next_pc;
    end

    // Target is kept even when not taken so the table can hold it
    always_comb begin
        update.valid    = issue.en;
        update.pc       = issue.pc;
        update.taken    = taken;
        update.target   = taken_target;
        update.category = category;
    end

    assign squash = redirect.flush;

endmodule

`default_nettype wire

/* logic/ex_issue_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_issue_reg
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  ex_issue_t issue_in,
    input  logic      squash,
    output ex_issue_t issue
);

    logic      en_q;
    ex_issue_t payload_q;

    // Wrong-path op behind a flush is dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= 1'b0;
        end else begin
            en_q <= issue_in.en && !squash;
        end
    end

    always_ff @(posedge clk) begin
        payload_q <= issue_in;
    end

    always_comb begin
        issue    = payload_q;
        issue.en = en_q;
    end

endmodule

`default_nettype wire

/* logic/ex_result_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_result_reg
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  br_wb_t       wb_in,
    input  br_redirect_t redirect_in,
    output br_wb_t       wb,
    output br_redirect_t redirect
);

    logic         wb_en_q;
    logic         flush_q;
    br_wb_t       wb_q;
    br_redirect_t redirect_q;

    // ------------------------------------------------------------------------
    // Strobes
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en_q <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            wb_en_q <= wb_in.en;
            flush_q <= redirect_in.flush;
        end
    end

    // Data fields
    always_ff @(posedge clk) begin
        wb_q       <= wb_in;
        redirect_q <= redirect_in;
    end

    always_comb begin
        wb             = wb_q;
        wb.en          = wb_en_q;
        redirect       = redirect_q;
        redirect.flush = flush_q;
    end

endmodule

`default_nettype wire

/* logic/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // ------------------------------------------------------------------------
    // Architectural widths
    // ------------------------------------------------------------------------

    // pc values, operands, offsets and link data
    typedef logic [31:0] word_t;

    // Architectural register number
    typedef logic [4:0] reg_addr_t;

    // ------------------------------------------------------------------------
    // Branch op codes as decode hands them to execute
    // ------------------------------------------------------------------------

    typedef enum logic [3:0] {
        JIRL = 4'b0011,
        B    = 4'b0100,
        BL   = 4'b0101,
        BEQ  = 4'b0110,
        BNE  = 4'b0111,
        BLT  = 4'b1000,
        BGE  = 4'b1001,
        BLTU = 4'b1010,
        BGEU = 4'b1011
    } branch_op_t;

    // Size of one instruction in bytes
    localparam int unsigned INSN_BYTES = 4;

    // Return address register written by BL
    localparam reg_addr_t LINK_REG = 5'd1;

endpackage

`default_nettype wire

/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // ------------------------------------------------------------------------
    // Branch classification, used by the predictor
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        COND     = 2'b01,
        DIRECT   = 2'b10,
        INDIRECT = 2'b11
    } br_category_t;

    // ------------------------------------------------------------------------
    // Pipeline bundles
    // ------------------------------------------------------------------------

    // One branch op from decode into execute
    typedef struct packed {
        logic       en;
        branch_op_t op;
        word_t      pc;
        word_t      pc_next;    // next pc assumed by fetch
        word_t      sr0;
        word_t      sr1;
        word_t      imm;        // sign-extended word offset
        reg_addr_t  rd;
    } ex_issue_t;

    // Link write towards writeback
    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } br_wb_t;

    // Redirect towards fetch
    typedef struct packed {
        logic  flush;
        word_t target;
    } br_redirect_t;

    // Training record for the predictor
    typedef struct packed {
        logic         valid;
        word_t        pc;
        logic         taken;
        word_t        target;
        br_category_t category;
    } bp_update_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module branch_ex_tb \
    -f all.f -o Vbranch_ex_tb

# The simulator may exit nonzero on failure, the log decides
./obj_dir/Vbranch_ex_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* test/branch_ex_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_ex_properties
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input ex_issue_t    issue,
    input br_wb_t       wb,
    input br_redirect_t redirect,
    input logic         squash
);

    // Failed assertions so far
    int unsigned fail_count = 0;

    // Outputs quiet while in reset
    assert property (@(posedge clk) !rst_n |-> !wb.en && !redirect.flush)
        else begin
            $error("wb.en or flush active during reset");
            fail_count++;
        end

    // Only JIRL and BL carry a link register
    assert property (@(posedge clk) disable iff (!rst_n)
        issue.en && (issue.op == B || issue.op == BEQ || issue.op == BNE ||
        issue.op == BLT || issue.op == BGE || issue.op == BLTU || issue.op == BGEU)
        |=> wb.rd == '0)
        else begin
            $error("nonzero wb.rd for a branch without link");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) squash |=> !issue.en)
        else begin
            $error("op behind a flush was not squashed");
            fail_count++;
        end

endmodule

bind branch_ex_top branch_ex_properties u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .wb       (wb),
    .redirect (redirect),
    .squash   (squash)
);

`default_nettype wire

/* test/branch_ex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_ex_tb
    import isa_pkg::*;
    import pipe_pkg::*;
;

    localparam int MAX_PATTERNS = 64;

    logic         clk;
    logic         rst_n;
    ex_issue_t    issue_in;
    br_wb_t       wb;
    br_redirect_t redirect;
    word_t        fetch_pc;
    logic         pred_hit;
    logic         pred_taken;
    word_t        pred_target;

    // One stored pattern per cycle
    logic [7:0] kind_a [MAX_PATTERNS];
    ex_issue_t  iss_a  [MAX_PATTERNS];
    word_t      exp_a  [MAX_PATTERNS][4];
    logic       live_a [MAX_PATTERNS];

    integer seed = 32'hcb69;
    integer n_pat = 0;
    integer cycles = 0;
    integer limit = 1000;

    branch_ex_top #(.BP_INDEX_BITS(4)) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_in    (issue_in),
        .wb          (wb),
        .redirect    (redirect),
        .fetch_pc    (fetch_pc),
        .pred_hit    (pred_hit),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: simulation ran past %0d cycles without finishing", limit);
            $display("Errors found");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (UUT.u_props.fail_count != 0) begin
            $display("A concurrent assertion on the DUT failed");
            $display("Errors found");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // Pattern loading and squash model
    // ------------------------------------------------------------------------

    task automatic load_patterns();
        integer fd;
        string  line;
        word_t  v [11];
        fd = $fopen("test/branch_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file test/branch_patterns.txt");
            $display("Errors found");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            kind_a[n_pat] = line.getc(0);
            iss_a[n_pat]  = '0;
            if (kind_a[n_pat] == "I") begin
                void'($sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                              v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]));
                iss_a[n_pat] = {1'b1, v[0][3:0], v[1], v[2], v[3], v[4], v[5], v[6][4:0]};
                exp_a[n_pat] = '{v[7], v[8], v[9], v[10]};
            end else if (kind_a[n_pat] == "L") begin
                void'($sscanf(line, "L %h %h %h %h", v[0], v[1], v[2], v[3]));
                iss_a[n_pat].pc = v[0];
                exp_a[n_pat]    = '{v[1], v[2], v[3], 32'd0};
            end
            // An op right behind a flushing op never executes
            live_a[n_pat] = (kind_a[n_pat] == "I") &&
                !(n_pat > 0 && live_a[n_pat-1] && exp_a[n_pat-1][0][0]);
            n_pat++;
        end
        $fclose(fd);
        limit = n_pat * 4 + 50;
    endtask

    task automatic drive_cycle(input integer c);
        ex_issue_t junk;
        junk     = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        junk.en  = 1'b0;
        fetch_pc <= word_t'($random(seed));
        if (c < n_pat && kind_a[c] == "I") begin
            issue_in <= iss_a[c];
        end else begin
            issue_in <= junk;
            if (c < n_pat && kind_a[c] == "L") begin
                fetch_pc <= iss_a[c].pc;
            end
        end
    endtask

    task automatic check_result(input integer c);
        if (live_a[c]) begin
            check_value("wb.en", 32'(wb.en), 32'd1);
            check_value("wb.rd", 32'(wb.rd), exp_a[c][2]);
            check_value("wb.data", wb.data, exp_a[c][3]);
            check_value("redirect.flush", 32'(redirect.flush), exp_a[c][0]);
            check_value("redirect.target", redirect.target, exp_a[c][1]);
        end else begin
            check_value("wb.en", 32'(wb.en), 32'd0);
            check_value("redirect.flush", 32'(redirect.flush), 32'd0);
        end
    endtask

    task automatic check_lookup(input integer c);
        check_value("pred_hit", 32'(pred_hit), exp_a[c][0]);
        check_value("pred_taken", 32'(pred_taken), exp_a[c][1]);
        if (exp_a[c][0][0]) begin
            check_value("pred_target", pred_target, exp_a[c][2]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        issue_in = '0;
        fetch_pc = '0;
        load_patterns();
        repeat (8) begin
            @(negedge clk);
            check_value("wb.en", 32'(wb.en), 32'd0);
            check_value("redirect.flush", 32'(redirect.flush), 32'd0);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        for (int c = 0; c < n_pat + 2; c++) begin
            @(posedge clk);
            drive_cycle(c);
            @(negedge clk);
            if (c >= 2) check_result(c - 2);
            if (c < n_pat && kind_a[c] == "L") check_lookup(c);
        end
        @(posedge clk);
        @(negedge clk);
        if (UUT.u_props.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/branch_patterns.txt */
# I op pc pc_next sr0 sr1 imm rd | exp_flush exp_target exp_wb_rd exp_data
# L fetch_pc | exp_hit exp_taken exp_target ; N is an idle cycle
L 00001000 0 0 00000000
I 6 00001000 00001010 00000005 00000005 00000004 03 0 00001010 00 00001004
I 7 00001020 00001024 00000005 00000005 00000008 04 0 00001024 00 00001024
I 8 00001040 00001030 ffffffff 00000001 fffffffc 02 0 00001030 00 00001044
I a 00001050 00001054 ffffffff 00000001 00000002 02 0 00001054 00 00001054
I 9 00001060 00001070 80000000 00000001 00000004 07 1 00001064 00 00001064
I b 00001070 0000107c 80000000 00000001 00000003 06 0 0000107c 00 00001074
I 4 00001080 00001084 00000000 00000000 00000010 09 1 000010c0 00 00001084
I 5 000010c0 000010c4 00000000 00000000 00000001 00 0 000010c4 01 000010c4
I 5 00002000 00002400 00000000 00000000 00000100 00 0 00002400 01 00002004
I 3 00002400 00002404 00003000 00000000 00000008 05 1 00003020 05 00002404
N
I b 00001100 00001110 80000000 00000001 00000004 08 0 00001110 00 00001104
I 6 00001200 00001204 00000001 00000002 00000008 0a 0 00001204 00 00001204
N
I 6 00001200 00001204 00000001 00000002 00000008 0a 0 00001204 00 00001204
N
N
L 00001200 1 0 00001220
L 00001000 0 0 00000000
L 00001050 1 0 00001058
L 00001060 1 0 00001070
L 00001020 0 0 00000000
I 3 00003044 00004004 00004000 00000000 00000001 1f 0 00004004 1f 00003048
N
N
L 00003044 1 1 00004004
